//--- src/apb_subsys_pkg.sv
`default_nettype none

package apb_subsys_pkg;

  // ------------------------------------------------
  // Bus widths
  // ------------------------------------------------
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int SLOT_W = 4;   // Address bits 15:12
  localparam int OFFS_W = 12;  // Address bits 11:0

  // Mapped APB slots, everything else answers PSLVERR
  typedef enum logic [SLOT_W-1:0] {
    SLOT_IO_REGS = 4'd8,
    SLOT_CFG     = 4'd15
  } apb_slot_t;

  // ------------------------------------------------
  // FPGA I/O register block
  // ------------------------------------------------
  localparam logic [OFFS_W-1:0] IO_LED_OFFS      = 12'h000;
  localparam logic [OFFS_W-1:0] IO_BUTTON_OFFS   = 12'h008;
  localparam logic [OFFS_W-1:0] IO_CNT100HZ_OFFS = 12'h010;
  localparam logic [OFFS_W-1:0] IO_MISC_OFFS     = 12'h04C;

  localparam int LED_W    = 2;
  localparam int BUTTON_W = 2;
  localparam int MISC_W   = 10;

  // ------------------------------------------------
  // Configuration register block
  // ------------------------------------------------
  localparam logic [OFFS_W-1:0] CFG_REG0_OFFS = 12'h000;
  localparam logic [OFFS_W-1:0] CFG_REG1_OFFS = 12'h004;
  localparam logic [OFFS_W-1:0] CFG_ID_OFFS   = 12'hFFC;

  localparam logic [DATA_W-1:0] CFG_ID_VALUE = 32'h0A9B_1001;

  // Bridge sequencing
  typedef enum logic [1:0] {
    ST_IDLE,    // Ready for an address phase
    ST_SETUP,   // APB setup cycle
    ST_ACCESS,  // APB access cycle
    ST_ERR      // First cycle of the AHB error response
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface apb_if
  import apb_subsys_pkg::*;
();

  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Requester side
  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  // Completer side
  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

//--- src/ahb_to_apb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_to_apb_ctrl
  import apb_subsys_pkg::*;
(
  input  logic              i_hclk,
  input  logic              i_rst,

  // AHB-lite slave side
  input  logic              i_hsel,
  input  logic [ADDR_W-1:0] i_haddr,
  input  logic [1:0]        i_htrans,
  input  logic              i_hwrite,
  input  logic              i_hready,
  input  logic [DATA_W-1:0] i_hwdata,
  output logic [DATA_W-1:0] o_hrdata,
  output logic              o_hresp,
  output logic              o_hreadyout,

  // APB master side
  apb_if.master             m_apb
);

  ctrl_state_t       state;
  ctrl_state_t       state_nxt;
  logic              accept;
  logic              xfer_done;
  logic [ADDR_W-1:0] addr_q;
  logic              write_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;
  logic              hresp_q;

  // NONSEQ or SEQ while we are free
  assign accept    = i_hsel & i_htrans[1] & i_hready & o_hreadyout;
  assign xfer_done = (state == ST_ACCESS) & m_apb.pready;

  // ------------------------------------------------
  // State machine
  // ------------------------------------------------
  always_comb begin
    state_nxt = state;
    unique case (state)
      ST_IDLE: begin
        if (accept) begin
          state_nxt = ST_SETUP;
        end
      end
      ST_SETUP: begin
        state_nxt = ST_ACCESS;
      end
      ST_ACCESS: begin
        if (m_apb.pready) begin
          state_nxt = m_apb.pslverr ? ST_ERR : ST_IDLE;
        end
      end
      ST_ERR: begin
        state_nxt = ST_IDLE;  // Second error cycle has hreadyout high
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      state   <= ST_IDLE;
      write_q <= 1'b0;
      hresp_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        write_q <= i_hwrite;
      end
      // Held through ST_ERR and the following ready cycle
      if (xfer_done && m_apb.pslverr) begin
        hresp_q <= 1'b1;
      end else if (state == ST_IDLE) begin
        hresp_q <= 1'b0;
      end
    end
  end

  // ------------------------------------------------
  // Address, write and read data capture
  // ------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q <= i_haddr;
    end
    if (state == ST_SETUP) begin
      wdata_q <= i_hwdata;  // First data phase cycle
    end
    if (xfer_done && !write_q) begin
      rdata_q <= m_apb.prdata;
    end
  end

  // APB outputs
  assign m_apb.paddr   = addr_q;
  assign m_apb.pwrite  = write_q;
  assign m_apb.psel    = (state == ST_SETUP) | (state == ST_ACCESS);
  assign m_apb.penable = (state == ST_ACCESS);
  // Setup takes hwdata straight from the bus, access uses the copy
  assign m_apb.pwdata  = (state == ST_SETUP) ? i_hwdata : wdata_q;

  // AHB response
  assign o_hreadyout = (state == ST_IDLE);
  assign o_hresp     = hresp_q;
  assign o_hrdata    = rdata_q;

endmodule

`default_nettype wire

//--- src/apb_slot_mux.sv
`timescale 1ns/1ps
`default_nettype none

module apb_slot_mux
  import apb_subsys_pkg::*;
(
  apb_if.slave  s_apb,    // From the bridge
  apb_if.master io_apb,   // Slot 8
  apb_if.master cfg_apb   // Slot 15
);

  logic [SLOT_W-1:0] slot;
  logic              hit_io;
  logic              hit_cfg;

  assign slot    = s_apb.paddr[ADDR_W-1 -: SLOT_W];
  assign hit_io  = (slot == SLOT_IO_REGS);
  assign hit_cfg = (slot == SLOT_CFG);

  // ------------------------------------------------
  // Request fan-out
  // ------------------------------------------------
  assign io_apb.paddr    = s_apb.paddr;
  assign io_apb.penable  = s_apb.penable;
  assign io_apb.pwrite   = s_apb.pwrite;
  assign io_apb.pwdata   = s_apb.pwdata;
  assign io_apb.psel     = s_apb.psel & hit_io;

  assign cfg_apb.paddr   = s_apb.paddr;
  assign cfg_apb.penable = s_apb.penable;
  assign cfg_apb.pwrite  = s_apb.pwrite;
  assign cfg_apb.pwdata  = s_apb.pwdata;
  assign cfg_apb.psel    = s_apb.psel & hit_cfg;

  // ------------------------------------------------
  // Response steering
  // ------------------------------------------------
  always_comb begin
    s_apb.prdata  = '0;
    s_apb.pready  = 1'b1;
    s_apb.pslverr = 1'b0;
    if (hit_io) begin
      s_apb.prdata  = io_apb.prdata;
      s_apb.pready  = io_apb.pready;
      s_apb.pslverr = io_apb.pslverr;
    end else if (hit_cfg) begin
      s_apb.prdata  = cfg_apb.prdata;
      s_apb.pready  = cfg_apb.pready;
      s_apb.pslverr = cfg_apb.pslverr;
    end else begin
      // Nothing lives here
      s_apb.pslverr = s_apb.psel;
    end
  end

endmodule

`default_nettype wire

//--- src/fpga_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_io_regs
  import apb_subsys_pkg::*;
(
  input  logic                i_hclk,
  input  logic                i_rst,
  input  logic                i_clk_100hz,  // Slow, asynchronous
  input  logic [BUTTON_W-1:0] i_buttons,    // Asynchronous
  output logic [LED_W-1:0]    o_leds,
  output logic [MISC_W-1:0]   o_fpga_misc,
  apb_if.slave                s_apb
);

  logic [OFFS_W-1:0]   offs;
  logic                wr_en;
  logic                rd_en;
  logic [BUTTON_W-1:0] btn_meta;
  logic [BUTTON_W-1:0] btn_sync;
  logic                tick_meta;
  logic                tick_sync;
  logic                tick_dly;
  logic                tick_rise;
  logic [LED_W-1:0]    led_q;
  logic [MISC_W-1:0]   misc_q;
  logic [DATA_W-1:0]   cnt_q;

  assign offs  = s_apb.paddr[OFFS_W-1:0];
  assign wr_en = s_apb.psel & s_apb.penable & s_apb.pwrite;
  assign rd_en = s_apb.psel & ~s_apb.pwrite;

  // ------------------------------------------------
  // Input synchronizers
  // ------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      btn_meta  <= '0;
      btn_sync  <= '0;
      tick_meta <= 1'b0;
      tick_sync <= 1'b0;
      tick_dly  <= 1'b0;
    end else begin
      btn_meta  <= i_buttons;
      btn_sync  <= btn_meta;
      tick_meta <= i_clk_100hz;
      tick_sync <= tick_meta;
      tick_dly  <= tick_sync;  // For edge detect
    end
  end

  assign tick_rise = tick_sync & ~tick_dly;

  // ------------------------------------------------
  // Registers
  // ------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      led_q  <= '0;
      misc_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (wr_en && offs == IO_LED_OFFS) begin
        led_q <= s_apb.pwdata[LED_W-1:0];
      end
      if (wr_en && offs == IO_MISC_OFFS) begin
        misc_q <= s_apb.pwdata[MISC_W-1:0];
      end
      // A load beats a tick in the same cycle
      if (wr_en && offs == IO_CNT100HZ_OFFS) begin
        cnt_q <= s_apb.pwdata;
      end else if (tick_rise) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Read back, unlisted offsets give 0
  always_comb begin
    s_apb.prdata = '0;
    if (rd_en) begin
      unique case (offs)
        IO_LED_OFFS:      s_apb.prdata = {{(DATA_W-LED_W){1'b0}}, led_q};
        IO_BUTTON_OFFS:   s_apb.prdata = {{(DATA_W-BUTTON_W){1'b0}}, btn_sync};
        IO_CNT100HZ_OFFS: s_apb.prdata = cnt_q;
        IO_MISC_OFFS:     s_apb.prdata = {{(DATA_W-MISC_W){1'b0}}, misc_q};
        default:          s_apb.prdata = '0;
      endcase
    end
  end

  assign s_apb.pready  = 1'b1;  // Zero wait
  assign s_apb.pslverr = 1'b0;

  assign o_leds      = led_q;
  assign o_fpga_misc = misc_q;

endmodule

`default_nettype wire

//--- src/cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  import apb_subsys_pkg::*;
(
  input  logic  i_hclk,
  input  logic  i_rst,
  output logic  o_zbt_boot_ctrl,  // ZBT boot select
  apb_if.slave  s_apb
);

  logic [OFFS_W-1:0] offs;
  logic              wr_en;
  logic              rd_en;
  logic [DATA_W-1:0] reg0_q;
  logic [DATA_W-1:0] reg1_q;

  assign offs  = s_apb.paddr[OFFS_W-1:0];
  assign wr_en = s_apb.psel & s_apb.penable & s_apb.pwrite;
  assign rd_en = s_apb.psel & ~s_apb.pwrite;

  // ------------------------------------------------
  // Read/write registers, ID write is dropped
  // ------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_rst) begin
      reg0_q <= '0;
      reg1_q <= '0;
    end else if (wr_en) begin
      if (offs == CFG_REG0_OFFS) begin
        reg0_q <= s_apb.pwdata;
      end
      if (offs == CFG_REG1_OFFS) begin
        reg1_q <= s_apb.pwdata;
      end
    end
  end

  always_comb begin
    s_apb.prdata = '0;
    if (rd_en) begin
      unique case (offs)
        CFG_REG0_OFFS: s_apb.prdata = reg0_q;
        CFG_REG1_OFFS: s_apb.prdata = reg1_q;
        CFG_ID_OFFS:   s_apb.prdata = CFG_ID_VALUE;
        default:       s_apb.prdata = '0;
      endcase
    end
  end

  assign s_apb.pready  = 1'b1;
  assign s_apb.pslverr = 1'b0;

  assign o_zbt_boot_ctrl = reg0_q[0];

endmodule

`default_nettype wire

//--- src/fpga_apb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_apb_subsystem
  import apb_subsys_pkg::*;
(
  input  logic                i_hclk,
  input  logic                i_rst,
  input  logic                i_clk_100hz,

  // AHB-lite slave port
  input  logic                i_hsel,
  input  logic [ADDR_W-1:0]   i_haddr,
  input  logic [1:0]          i_htrans,
  input  logic                i_hwrite,
  input  logic                i_hready,
  input  logic [DATA_W-1:0]   i_hwdata,
  output logic [DATA_W-1:0]   o_hrdata,
  output logic                o_hresp,
  output logic                o_hreadyout,

  // Board pins
  output logic [LED_W-1:0]    o_leds,
  input  logic [BUTTON_W-1:0] i_buttons,
  output logic [MISC_W-1:0]   o_fpga_misc,
  output logic                o_zbt_boot_ctrl
);

  apb_if m_apb ();    // Bridge to mux
  apb_if io_apb ();   // Slot 8
  apb_if cfg_apb ();  // Slot 15

  // ------------------------------------------------
  // AHB to APB bridge
  // ------------------------------------------------
  ahb_to_apb_ctrl u_ctrl (
    .i_hclk      (i_hclk),
    .i_rst       (i_rst),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hready    (i_hready),
    .i_hwdata    (i_hwdata),
    .o_hrdata    (o_hrdata),
    .o_hresp     (o_hresp),
    .o_hreadyout (o_hreadyout),
    .m_apb       (m_apb)
  );

  apb_slot_mux u_mux (
    .s_apb   (m_apb),
    .io_apb  (io_apb),
    .cfg_apb (cfg_apb)
  );

  // ------------------------------------------------
  // Peripherals
  // ------------------------------------------------
  fpga_io_regs u_io (
    .i_hclk      (i_hclk),
    .i_rst       (i_rst),
    .i_clk_100hz (i_clk_100hz),
    .i_buttons   (i_buttons),
    .o_leds      (o_leds),
    .o_fpga_misc (o_fpga_misc),
    .s_apb       (io_apb)
  );

  cfg_regs u_cfg (
    .i_hclk          (i_hclk),
    .i_rst           (i_rst),
    .o_zbt_boot_ctrl (o_zbt_boot_ctrl),
    .s_apb           (cfg_apb)
  );

endmodule

`default_nettype wire

//--- bench/apb_subsys_props.sv
`timescale 1ns/1ps
`default_nettype none

module apb_subsys_props
  import apb_subsys_pkg::*;
(
  input  logic              i_hclk,
  input  logic              i_rst,
  input  logic              i_hsel,
  input  logic [1:0]        i_htrans,
  input  logic              i_hready,
  input  logic              i_hreadyout,
  input  logic              i_hresp,
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic [ADDR_W-1:0] i_paddr
);

  logic accept;
  int   fail_cnt = 0;  // Polled by the testbench

  assign accept = i_hsel & i_htrans[1] & i_hready & i_hreadyout;

  // ------------------------------------------------
  // APB phase sequencing
  // ------------------------------------------------
  a_setup_then_access: assert property (
    @(posedge i_hclk) disable iff (i_rst)
    i_psel && !i_penable |=> i_psel && i_penable
  ) else begin
    $error("APB setup cycle not followed by an access cycle");
    fail_cnt++;
  end

  a_paddr_stable: assert property (
    @(posedge i_hclk) disable iff (i_rst)
    i_psel && !i_penable |=> $stable(i_paddr)
  ) else begin
    $error("paddr changed between setup and access");
    fail_cnt++;
  end

  // ------------------------------------------------
  // AHB response shape
  // ------------------------------------------------
  a_err_two_cycle: assert property (
    @(posedge i_hclk) disable iff (i_rst)
    i_hresp && !i_hreadyout |=> i_hresp && i_hreadyout
  ) else begin
    $error("Error response is not low then high hreadyout with hresp held");
    fail_cnt++;
  end

  a_err_starts_low: assert property (
    @(posedge i_hclk) disable iff (i_rst)
    $rose(i_hresp) |-> !i_hreadyout
  ) else begin
    $error("Error response started with hreadyout high");
    fail_cnt++;
  end

  // Two wait cycles, then OK completion or the first error cycle
  a_fixed_wait: assert property (
    @(posedge i_hclk) disable iff (i_rst)
    accept |=> !i_hreadyout ##1 !i_hreadyout ##1 (i_hreadyout || i_hresp)
  ) else begin
    $error("hreadyout not low for exactly two cycles after an accepted transfer");
    fail_cnt++;
  end

endmodule

bind ahb_to_apb_ctrl apb_subsys_props u_props (
  .i_hclk      (i_hclk),
  .i_rst       (i_rst),
  .i_hsel      (i_hsel),
  .i_htrans    (i_htrans),
  .i_hready    (i_hready),
  .i_hreadyout (o_hreadyout),
  .i_hresp     (o_hresp),
  .i_psel      (m_apb.psel),
  .i_penable   (m_apb.penable),
  .i_paddr     (m_apb.paddr)
);

`default_nettype wire

//--- bench/tb_fpga_apb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_apb_subsystem
  import apb_subsys_pkg::*;
();

  logic                clk = 1'b0;
  logic                rst;
  logic                clk_100hz;
  logic                hsel;
  logic [ADDR_W-1:0]   haddr;
  logic [1:0]          htrans;
  logic                hwrite;
  logic                hready;
  logic [DATA_W-1:0]   hwdata;
  logic [DATA_W-1:0]   hrdata;
  logic                hresp;
  logic                hreadyout;
  logic [LED_W-1:0]    leds;
  logic [BUTTON_W-1:0] buttons;
  logic [MISC_W-1:0]   misc;
  logic                boot;

  // Reference model of the mapped registers
  logic [LED_W-1:0]    m_led;
  logic [MISC_W-1:0]   m_misc;
  logic [DATA_W-1:0]   m_cnt;
  logic [DATA_W-1:0]   m_reg0;
  logic [DATA_W-1:0]   m_reg1;
  string               test_name;
  int                  timeout_cyc = 64;

  fpga_apb_subsystem u_dut (
    .i_hclk (clk), .i_rst (rst), .i_clk_100hz (clk_100hz),
    .i_hsel (hsel), .i_haddr (haddr), .i_htrans (htrans), .i_hwrite (hwrite),
    .i_hready (hready), .i_hwdata (hwdata), .o_hrdata (hrdata), .o_hresp (hresp),
    .o_hreadyout (hreadyout), .o_leds (leds), .i_buttons (buttons),
    .o_fpga_misc (misc), .o_zbt_boot_ctrl (boot)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string what, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("MISMATCH %s %s: expected 0x%08h, actual 0x%08h",
                          test_name, what, exp, act));
    end
  endtask

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic logic exp_error(input logic [ADDR_W-1:0] addr);
    return !(addr[15:12] == SLOT_IO_REGS || addr[15:12] == SLOT_CFG);
  endfunction

  function automatic logic [DATA_W-1:0] exp_rdata(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] d;
    d = '0;  // Unlisted offsets read 0
    if (addr[15:12] == SLOT_IO_REGS) begin
      case (addr[11:0])
        IO_LED_OFFS:      d = DATA_W'(m_led);
        IO_BUTTON_OFFS:   d = DATA_W'(buttons);
        IO_CNT100HZ_OFFS: d = m_cnt;
        IO_MISC_OFFS:     d = DATA_W'(m_misc);
        default:          d = '0;
      endcase
    end else if (addr[15:12] == SLOT_CFG) begin
      case (addr[11:0])
        CFG_REG0_OFFS: d = m_reg0;
        CFG_REG1_OFFS: d = m_reg1;
        CFG_ID_OFFS:   d = CFG_ID_VALUE;
        default:       d = '0;
      endcase
    end
    return d;
  endfunction

  function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data);
    if (addr[15:12] == SLOT_IO_REGS) begin
      case (addr[11:0])
        IO_LED_OFFS:      m_led = data[LED_W-1:0];
        IO_CNT100HZ_OFFS: m_cnt = data;
        IO_MISC_OFFS:     m_misc = data[MISC_W-1:0];
        default:          ;  // Buttons and holes ignore writes
      endcase
    end else if (addr[15:12] == SLOT_CFG) begin
      if (addr[11:0] == CFG_REG0_OFFS) m_reg0 = data;
      if (addr[11:0] == CFG_REG1_OFFS) m_reg1 = data;
    end
  endfunction

  function automatic logic [SLOT_W-1:0] unmapped_slot();
    logic [SLOT_W-1:0] s;
    s = SLOT_W'($urandom_range(0, 13));
    if (s >= 4'd8) s = s + 1'b1;  // Slots 9 to 14 above slot 8
    return s;
  endfunction

  // Offsets of writable registers in the mapped blocks
  function automatic logic [OFFS_W-1:0] reg_offs(input int k);
    case (k)
      0:       return IO_LED_OFFS;  // Same offset as CFG_REG0
      1:       return CFG_REG1_OFFS;
      2:       return IO_CNT100HZ_OFFS;
      default: return IO_MISC_OFFS;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] pick_addr();
    case ($urandom_range(0, 8))
      0:       return {SLOT_IO_REGS, IO_LED_OFFS};
      1:       return {SLOT_IO_REGS, IO_BUTTON_OFFS};
      2:       return {SLOT_IO_REGS, IO_CNT100HZ_OFFS};
      3:       return {SLOT_IO_REGS, IO_MISC_OFFS};
      4:       return {SLOT_CFG, CFG_REG0_OFFS};
      5:       return {SLOT_CFG, CFG_REG1_OFFS};
      6:       return {SLOT_CFG, CFG_ID_OFFS};
      7:       return {SLOT_IO_REGS, 12'h020};  // Hole in the I/O block
      default: return {unmapped_slot(), 10'($urandom()), 2'b00};
    endcase
  endfunction

  // ------------------------------------------------
  // AHB driver
  // ------------------------------------------------
  task automatic drive_addr(input logic wr, input logic [ADDR_W-1:0] addr);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;  // NONSEQ
    hwrite <= wr;
  endtask

  task automatic drive_idle();
    hsel   <= 1'b0;
    htrans <= 2'b00;
  endtask

  // Returns at the falling edge of the first cycle with o_hreadyout high
  task automatic wait_ready(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!hreadyout && n < timeout_cyc) begin
      n++;
      @(negedge clk);
    end
    if (!hreadyout) begin
      abort_run($sformatf("Timeout: o_hreadyout stayed low in the %s of %s",
                          what, test_name));
    end
  endtask

  task automatic check_completion(input logic wr, input logic [ADDR_W-1:0] addr,
                                  input logic [DATA_W-1:0] wdata);
    logic err;
    err = exp_error(addr);
    check_value($sformatf("hresp at 0x%04h", addr), DATA_W'(err), DATA_W'(hresp));
    if (!err && wr) model_write(addr, wdata);
    if (!err && !wr) check_value($sformatf("read of 0x%04h", addr), exp_rdata(addr), hrdata);
  endtask

  task automatic ahb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata);
    @(posedge clk);
    drive_addr(wr, addr);
    wait_ready("address phase");
    @(posedge clk);  // Accepted here
    drive_idle();
    hwdata <= wdata;
    wait_ready("data phase");
  endtask

  task automatic ahb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    ahb_xfer(1'b1, addr, data);
    check_completion(1'b1, addr, data);
  endtask

  task automatic ahb_read(input logic [ADDR_W-1:0] addr);
    ahb_xfer(1'b0, addr, '0);
    check_completion(1'b0, addr, '0);
  endtask

  task automatic check_all_regs();
    ahb_read({SLOT_IO_REGS, IO_LED_OFFS});
    ahb_read({SLOT_IO_REGS, IO_BUTTON_OFFS});
    ahb_read({SLOT_IO_REGS, IO_CNT100HZ_OFFS});
    ahb_read({SLOT_IO_REGS, IO_MISC_OFFS});
    ahb_read({SLOT_CFG, CFG_REG0_OFFS});
    ahb_read({SLOT_CFG, CFG_REG1_OFFS});
    ahb_read({SLOT_CFG, CFG_ID_OFFS});
  endtask

  // Next address goes out with the current data, so it is taken in the completion cycle
  task automatic run_back_to_back(input int n);
    logic              op_wr[$];
    logic [ADDR_W-1:0] op_addr[$];
    logic [DATA_W-1:0] op_data[$];
    for (int i = 0; i < n; i++) begin
      op_wr.push_back(1'($urandom_range(0, 1)));
      op_addr.push_back(pick_addr());
      op_data.push_back($urandom());
    end
    @(posedge clk);
    drive_addr(op_wr[0], op_addr[0]);
    for (int i = 0; i < n; i++) begin
      wait_ready("back-to-back address phase");
      if (i > 0) check_completion(op_wr[i-1], op_addr[i-1], op_data[i-1]);
      @(posedge clk);
      hwdata <= op_data[i];
      if (i + 1 < n) begin
        drive_addr(op_wr[i+1], op_addr[i+1]);
      end else begin
        drive_idle();
      end
    end
    wait_ready("last data phase");
    check_completion(op_wr[n-1], op_addr[n-1], op_data[n-1]);
  endtask

  // Watch the bound protocol checks
  always @(negedge clk) begin
    if (u_dut.u_ctrl.u_props.fail_cnt != 0) begin
      abort_run("A bound protocol assertion failed");
    end
  end

  initial begin
    int n_ticks;
    logic [ADDR_W-1:0] addr;
    void'($urandom(32'hcd60));
    rst = 1'b1;
    clk_100hz = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hready = 1'b1;  // No other slave on the bus
    hwdata = '0;
    buttons = 2'b10;
    m_led = '0;
    m_misc = '0;
    m_cnt = '0;
    m_reg0 = '0;
    m_reg1 = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    test_name = "reset";
    @(negedge clk);
    check_value("o_hreadyout", 1, DATA_W'(hreadyout));
    check_value("o_hresp", 0, DATA_W'(hresp));
    check_value("o_leds", 0, DATA_W'(leds));
    check_value("o_fpga_misc", 0, DATA_W'(misc));
    check_value("o_zbt_boot_ctrl", 0, DATA_W'(boot));

    test_name = "led_misc";
    for (int i = 0; i < 4; i++) begin
      ahb_write({SLOT_IO_REGS, IO_LED_OFFS}, $urandom());
      ahb_write({SLOT_IO_REGS, IO_MISC_OFFS}, $urandom());
      check_value("o_leds", DATA_W'(m_led), DATA_W'(leds));
      check_value("o_fpga_misc", DATA_W'(m_misc), DATA_W'(misc));
      ahb_read({SLOT_IO_REGS, IO_LED_OFFS});
      ahb_read({SLOT_IO_REGS, IO_MISC_OFFS});
    end

    test_name = "buttons";
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      buttons <= BUTTON_W'(i);
      repeat (4) @(posedge clk);
      ahb_read({SLOT_IO_REGS, IO_BUTTON_OFFS});
    end

    test_name = "tick_counter";
    ahb_write({SLOT_IO_REGS, IO_CNT100HZ_OFFS}, 32'd0);
    n_ticks = $urandom_range(3, 8);
    for (int i = 0; i < n_ticks; i++) begin
      @(posedge clk);
      clk_100hz <= 1'b1;
      repeat (6) @(posedge clk);
      clk_100hz <= 1'b0;
      repeat (6) @(posedge clk);
    end
    m_cnt = m_cnt + n_ticks;
    ahb_read({SLOT_IO_REGS, IO_CNT100HZ_OFFS});

    test_name = "cfg_regs";
    for (int i = 0; i < 4; i++) begin
      ahb_write({SLOT_CFG, CFG_REG0_OFFS}, $urandom());
      ahb_write({SLOT_CFG, CFG_REG1_OFFS}, $urandom());
      ahb_read({SLOT_CFG, CFG_REG0_OFFS});
      ahb_read({SLOT_CFG, CFG_REG1_OFFS});
      check_value("o_zbt_boot_ctrl", DATA_W'(m_reg0[0]), DATA_W'(boot));
    end
    ahb_read({SLOT_CFG, CFG_ID_OFFS});
    ahb_write({SLOT_CFG, CFG_ID_OFFS}, $urandom());
    ahb_read({SLOT_CFG, CFG_ID_OFFS});

    test_name = "unmapped";
    for (int i = 0; i < 4; i++) begin
      addr = {unmapped_slot(), reg_offs(i)};
      ahb_write(addr, $urandom());
      ahb_read(addr);
      check_all_regs();
    end

    test_name = "back_to_back";
    run_back_to_back(40);

    repeat (4) @(posedge clk);
    if (u_dut.u_ctrl.u_props.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("A bound protocol assertion failed at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- list.f
src/apb_subsys_pkg.sv
src/apb_if.sv
src/ahb_to_apb_ctrl.sv
src/apb_slot_mux.sv
src/fpga_io_regs.sv
src/cfg_regs.sv
src/fpga_apb_subsystem.sv
bench/apb_subsys_props.sv
bench/tb_fpga_apb_subsystem.sv
